// File: Makefile
VERILATOR ?= verilator
TOP       ?= memStageTb
RTL_TOP   ?= memStage
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= list.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// File: bench/memStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module memStageTb import memStagePkg::*; ();

    localparam int NUM_CYCLES = 600;

    typedef struct packed {
        dataReq_t    req;
        logic        flush;
        logic [31:0] vector;
        logic [31:0] fwdResult;
        logic        fwdRegWr;
        logic        taken;
        logic [4:0]  code;
        logic        isEret;
    } expect_t;

    logic          clk;
    logic          rst;
    logic          memWr;
    logic          memFlush;
    logic          disWr;
    logic [5:0]    hwInt;
    exeMemBundle_t exeIn;
    dataReq_t      dataReq;
    logic          flush;
    logic [31:0]   vector;
    logic [31:0]   epc;
    logic [31:0]   memPc;
    logic [4:0]    fwdDst;
    logic [31:0]   fwdResult;
    logic          fwdRegWr;

    integer seed = 70;
    integer errors = 0;

    // shadow of the stage register and the CP0 state
    exeMemBundle_t shB;
    logic          shDs;
    logic          shBev;
    logic [7:0]    shIm;
    logic          shExl;
    logic          shIe;
    logic [7:0]    shIp;
    logic          shBd;
    logic [4:0]    shCode;
    logic [31:0]   shEpc;
    logic [31:0]   shBadV;

    memStage i_dut (
        .clk       (clk),
        .rst       (rst),
        .memWr     (memWr),
        .memFlush  (memFlush),
        .disWr     (disWr),
        .hwInt     (hwInt),
        .exeIn     (exeIn),
        .dataReq   (dataReq),
        .flush     (flush),
        .vector    (vector),
        .epc       (epc),
        .memPc     (memPc),
        .fwdDst    (fwdDst),
        .fwdResult (fwdResult),
        .fwdRegWr  (fwdRegWr)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] readCp0(input logic [4:0] num);
        case (num)
            5'd8:  return shBadV;
            5'd12: return {9'd0, shBev, 6'd0, shIm, 6'd0, shExl, shIe};
            5'd13: return {shBd, 15'd0, shIp, 1'b0, shCode, 2'b00};
            5'd14: return shEpc;
            default: return 32'd0;
        endcase
    endfunction

    function automatic expect_t refOut(input exeMemBundle_t b, input logic ds,
                                       input logic dis);
        expect_t e;
        logic [1:0] al;
        logic ldMis;
        logic stMis;
        logic intP;
        e = '0;
        al = b.aluOut[1:0];
        ldMis = (((b.loadKind == ldHalf) || (b.loadKind == ldHalfU)) && al[0]) ||
                ((b.loadKind == ldWord) && (al != 2'b00));
        stMis = ((b.storeKind == stHalf) && al[0]) || ((b.storeKind == stWord) && (al != 2'b00));
        e.req.wdata = b.storeData;
        if (b.storeKind == stByte) begin
            e.req.wstrb = 4'b0001 << al;
            e.req.wdata = {4{b.storeData[7:0]}};
        end else if (b.storeKind == stHalf) begin
            e.req.wstrb = al[1] ? 4'b1100 : 4'b0011;
            e.req.wdata = {2{b.storeData[15:0]}};
        end else if (b.storeKind == stWord) begin
            e.req.wstrb = 4'b1111;
        end
        // kseg0 = 100, kseg1 = 101
        if (b.aluOut[31:30] == 2'b10) begin
            e.req.physAddr = {3'b000, b.aluOut[28:0]};
        end else begin
            e.req.physAddr = b.aluOut;
        end
        e.req.cached = (b.aluOut[31:29] != 3'b101);
        e.req.write = (b.storeKind != stNone);
        intP = ((shIp & shIm) != 0) && shIe && !shExl && !ds && (b.pc != 0);
        e.taken = 1'b1;
        if (intP) e.code = 5'd0;
        else if (ldMis) e.code = 5'd4;
        else if (stMis) e.code = 5'd5;
        else if (b.excFlags.reservedInstr) e.code = 5'd10;
        else if (b.excFlags.syscall) e.code = 5'd8;
        else if (b.excFlags.brk) e.code = 5'd9;
        else if (b.excFlags.overflow) e.code = 5'd12;
        else begin
            e.taken = 1'b0;
            e.isEret = b.excFlags.eret;
        end
        e.flush = e.taken || e.isEret;
        e.vector = e.isEret ? shEpc : (shBev ? 32'hBFC0_0380 : 32'h8000_0180);
        e.req.valid = ((b.loadKind != ldNone) || (b.storeKind != stNone)) && !e.taken && !dis;
        e.fwdResult = b.cp0Rd ? readCp0(b.aluOut[4:0]) : b.aluOut;
        e.fwdRegWr = b.regWr && !dis && !e.taken;
        return e;
    endfunction

    // shadow update reads the values present before this edge
    always @(posedge clk) begin
        expect_t e;
        logic [31:0] d;
        if (rst) begin
            shBev = 1'b1;
            shIm = 8'h00;
            shExl = 1'b0;
            shIe = 1'b0;
            shIp = 8'h00;
            shBd = 1'b0;
            shCode = 5'd0;
            shB = '0;
            shDs = 1'b0;
        end else begin
            e = refOut(shB, shDs, disWr);
            d = shB.storeData;
            shIp[7:2] = hwInt;
            if (e.taken && !disWr) begin
                shExl = 1'b1;
                shBd = shDs;
                shCode = e.code;
                shEpc = shDs ? shB.pc - 32'd4 : shB.pc;
                if ((e.code == 5'd4) || (e.code == 5'd5)) shBadV = shB.aluOut;
            end else if (e.isEret && !disWr) begin
                shExl = 1'b0;
            end else if (shB.cp0Wr && !disWr) begin
                case (shB.aluOut[4:0])
                    5'd12: begin
                        shBev = d[22];
                        shIm = d[15:8];
                        shExl = d[1];
                        shIe = d[0];
                    end
                    5'd13: shIp[1:0] = d[9:8];
                    5'd14: shEpc = d;
                    default: ;
                endcase
            end
            if (memFlush) begin
                shB = '0;
                shDs = 1'b0;
            end else if (memWr) begin
                shDs = shB.isBranch;
                shB = exeIn;
            end
        end
    end

    task automatic checkVal(input string name, input logic [79:0] got, input logic [79:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED time=%0t signal=%s got=%h exp=%h", $time, name, got, exp);
            errors = errors + 1;
        end
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (!rst) begin
            e = refOut(shB, shDs, disWr);
            checkVal("dataReq", dataReq, e.req);
            checkVal("flush", flush, e.flush);
            if (e.flush) checkVal("vector", vector, e.vector);
            checkVal("fwdResult", fwdResult, e.fwdResult);
            checkVal("fwdRegWr", fwdRegWr, e.fwdRegWr);
            checkVal("fwdDst", fwdDst, shB.dst);
            checkVal("memPc", memPc, shB.pc);
            checkVal("epc", epc, shEpc);
        end
    end

    function automatic exeMemBundle_t aluOp(input logic [31:0] pc, input logic [31:0] val,
                                            input logic br);
        exeMemBundle_t b;
        b = '0;
        b.pc = pc;
        b.aluOut = val;
        b.dst = 5'd3;
        b.regWr = 1'b1;
        b.isBranch = br;
        return b;
    endfunction

    function automatic exeMemBundle_t cp0Op(input logic [31:0] pc, input logic [4:0] num,
                                            input logic wr, input logic [31:0] data);
        exeMemBundle_t b;
        b = '0;
        b.pc = pc;
        b.aluOut = {27'd0, num};
        b.storeData = data;
        b.dst = 5'd9;
        b.cp0Wr = wr;
        b.cp0Rd = !wr;
        b.regWr = !wr;
        return b;
    endfunction

    function automatic exeMemBundle_t memOp(input logic [31:0] pc, input logic [31:0] addr,
                                            input logic [2:0] ld, input logic [1:0] st);
        exeMemBundle_t b;
        b = '0;
        b.pc = pc;
        b.aluOut = addr;
        b.storeData = 32'hA5C3_1E77 ^ addr;
        b.loadKind = loadKind_t'(ld);
        b.storeKind = storeKind_t'(st);
        b.regWr = (ld != 3'd0);
        b.dst = 5'd4;
        return b;
    endfunction

    function automatic exeMemBundle_t flagOp(input logic [31:0] pc, input excFlags_t f);
        exeMemBundle_t b;
        b = aluOp(pc, 32'h0, 1'b0);
        b.excFlags = f;
        return b;
    endfunction

    task automatic issue(input exeMemBundle_t b);
        @(posedge clk);
        exeIn <= b;
        memWr <= 1'b1;
    endtask

    // issue and wait until the instruction sits in MEM
    task automatic issueWait(input exeMemBundle_t b);
        issue(b);
        @(posedge clk);
        exeIn <= '0;
        @(negedge clk);
    endtask

    task automatic expectRead(input logic [4:0] num, input logic [31:0] mask,
                              input logic [31:0] exp, input string name);
        issueWait(cp0Op(32'h0000_0400, num, 1'b0, 32'd0));
        checkVal(name, fwdResult & mask, exp);
    endtask

    task automatic expectFlush(input exeMemBundle_t b, input logic exp,
                               input logic [31:0] vec);
        issueWait(b);
        checkVal("flush", flush, exp);
        if (exp) checkVal("vector", vector, vec);
    endtask

    initial begin
        integer i;
        logic [2:0] k;
        logic [31:0] a;
        clk = 1'b0;
        rst = 1'b1;
        memWr = 1'b0;
        memFlush = 1'b0;
        disWr = 1'b0;
        hwInt = 6'd0;
        exeIn = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // random aligned accesses across all segments
        for (i = 0; i < 200; i = i + 1) begin
            k = $random(seed) % 8;
            a = $random(seed);
            if (k < 3) issue(memOp(32'h1000 + 4 * i, {a[31:2], 2'b00}, 3'd5, 2'd0));
            else if (k == 3) issue(memOp(32'h1000 + 4 * i, {a[31:1], 1'b0}, 3'd3, 2'd0));
            else if (k == 4) issue(memOp(32'h1000 + 4 * i, a, 3'd2, 2'd0));
            else if (k == 5) issue(memOp(32'h1000 + 4 * i, a, 3'd0, 2'd1));
            else if (k == 6) issue(memOp(32'h1000 + 4 * i, {a[31:1], 1'b0}, 3'd0, 2'd2));
            else issue(memOp(32'h1000 + 4 * i, {a[31:2], 2'b00}, 3'd0, 2'd3));
        end

        // misaligned half load then word store
        expectFlush(memOp(32'h0000_0100, 32'h8000_1001, 3'd3, 2'd0), 1'b1, VEC_BOOT);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_ADEL, 2'b00}, "cause.code");
        expectRead(CP0_EPC, 32'hFFFF_FFFF, 32'h0000_0100, "epc");
        expectRead(CP0_BADVADDR, 32'hFFFF_FFFF, 32'h8000_1001, "badVAddr");
        expectFlush(memOp(32'h0000_0104, 32'hA000_0022, 3'd0, 2'd3), 1'b1, VEC_BOOT);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_ADES, 2'b00}, "cause.code");
        expectRead(CP0_BADVADDR, 32'hFFFF_FFFF, 32'hA000_0022, "badVAddr");

        // clear BEV and EXL, then synchronous causes
        issueWait(cp0Op(32'h0000_0180, CP0_STATUS, 1'b1, 32'd0));
        expectFlush(flagOp(32'h0000_0200, 5'b10000), 1'b1, VEC_NORMAL);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_SYS, 2'b00}, "cause.code");
        expectFlush(flagOp(32'h0000_0204, 5'b01000), 1'b1, VEC_NORMAL);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_BP, 2'b00}, "cause.code");
        expectFlush(flagOp(32'h0000_0208, 5'b00100), 1'b1, VEC_NORMAL);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_RI, 2'b00}, "cause.code");
        expectFlush(flagOp(32'h0000_020C, 5'b00010), 1'b1, VEC_NORMAL);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_OV, 2'b00}, "cause.code");
        // branch followed by a syscall in its delay slot
        issue(aluOp(32'h0000_0300, 32'h5, 1'b1));
        expectFlush(flagOp(32'h0000_0304, 5'b10000), 1'b1, VEC_NORMAL);
        expectRead(CP0_EPC, 32'hFFFF_FFFF, 32'h0000_0300, "epc");
        expectRead(CP0_CAUSE, 32'h8000_0000, 32'h8000_0000, "cause.bd");

        // interrupts with IE and all IM bits on
        issueWait(cp0Op(32'h0000_0500, CP0_STATUS, 1'b1, 32'h0000_FF01));
        @(posedge clk);
        hwInt <= 6'b000001;
        expectFlush(aluOp(32'h0000_0600, 32'h1, 1'b0), 1'b1, VEC_NORMAL);
        expectRead(CP0_CAUSE, 32'h7C, {25'd0, EXC_INT, 2'b00}, "cause.code");
        expectFlush(aluOp(32'h0000_0604, 32'h2, 1'b0), 1'b0, 32'd0);
        @(posedge clk);
        hwInt <= 6'b000000;
        expectFlush(flagOp(32'h0000_0608, 5'b00001), 1'b1, 32'h0000_0600);
        expectRead(CP0_STATUS, 32'h2, 32'h0, "status.exl");
        issueWait(cp0Op(32'h0000_0700, CP0_CAUSE, 1'b1, 32'h0000_0100));
        expectFlush(aluOp(32'h0000_0704, 32'h3, 1'b0), 1'b1, VEC_NORMAL);
        issueWait(cp0Op(32'h0000_0708, CP0_CAUSE, 1'b1, 32'h0));
        expectFlush(flagOp(32'h0000_070C, 5'b00001), 1'b1, 32'h0000_0704);

        // stall holds the request
        issue(memOp(32'h0000_0800, 32'h8000_0040, 3'd5, 2'd0));
        @(posedge clk);
        memWr <= 1'b0;
        exeIn <= memOp(32'h0000_0804, 32'h0000_0044, 3'd0, 2'd3);
        repeat (4) @(posedge clk);
        memWr <= 1'b1;
        // disWr blocks the request, fwdRegWr and mtc0
        disWr <= 1'b1;
        issue(cp0Op(32'h0000_0900, CP0_STATUS, 1'b1, 32'h0040_0000));
        issue(memOp(32'h0000_0904, 32'h0000_0080, 3'd0, 2'd3));
        issue(aluOp(32'h0000_0908, 32'h7, 1'b0));
        repeat (2) @(posedge clk);
        disWr <= 1'b0;
        expectRead(CP0_STATUS, 32'h0040_0000, 32'h0, "status.bev");
        // flush loads a bubble
        issue(memOp(32'h0000_0A00, 32'h0000_00C0, 3'd5, 2'd0));
        memFlush <= 1'b1;
        @(posedge clk);
        memFlush <= 1'b0;
        exeIn <= '0;
        @(negedge clk);
        checkVal("dataReq.valid", dataReq.valid, 1'b0);
        checkVal("fwdRegWr", fwdRegWr, 1'b0);
        repeat (3) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_CYCLES * 20 + 2000);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/memStagePkg.sv
verilog/memStageReg.sv
verilog/memAccessAlign.sv
verilog/addrMapper.sv
verilog/exceptionUnit.sv
verilog/cp0Regs.sv
verilog/memStage.sv
bench/memStageTb.sv

// File: verilog/addrMapper.sv
`timescale 1ns/1ps
`default_nettype none

module addrMapper import memStagePkg::*; (
    input  logic [31:0] virtAddr,
    output logic [31:0] physAddr,
    output logic        cached
);

    logic [2:0] seg;
    logic       unmapped;

    assign seg = virtAddr[31:29];

    // kseg0 and kseg1 both alias the low 512 MB
    assign unmapped = (seg == SEG_KSEG0) || (seg == SEG_KSEG1);

    // kuseg and kseg2/3 pass through as there is no TLB
    assign physAddr = unmapped ? {3'b000, virtAddr[28:0]} : virtAddr;

    // only kseg1 bypasses the cache
    assign cached = (seg != SEG_KSEG1);

endmodule

`default_nettype wire

// File: verilog/cp0Regs.sv
`timescale 1ns/1ps
`default_nettype none

module cp0Regs import memStagePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic [5:0]    hwInt,
    input  logic          disWr,
    input  exeMemBundle_t memBundle,
    input  logic          inDelaySlot,
    input  excInfo_t      exc,
    output logic [31:0]   cp0RdData,
    output logic          statusBev,
    output logic          statusExl,
    output logic          intPending,
    output logic [31:0]   epc
);

    status_t     status;
    status_t     wrStatus;
    logic [7:0]  causeIp;
    logic        causeBd;
    logic [4:0]  causeExcCode;
    logic [31:0] badVAddr;
    logic [31:0] causeWord;
    logic [4:0]  regNum;
    logic        commitExc;
    logic        commitEret;
    logic        mtc0;

    assign regNum = memBundle.aluOut[4:0];
    assign wrStatus = status_t'(memBundle.storeData);

    // nothing architectural changes while the stage is held downstream
    assign commitExc = exc.taken && !disWr;
    assign commitEret = exc.isEret && !disWr;
    assign mtc0 = memBundle.cp0Wr && !exc.taken && !disWr;

    always_ff @(posedge clk) begin
        if (rst) begin
            status <= status_t'(STATUS_RESET);
            causeIp <= 8'h00;
            causeBd <= 1'b0;
            causeExcCode <= 5'd0;
        end else begin
            // hardware lines sampled every cycle
            causeIp[7:2] <= hwInt;
            if (commitExc) begin
                status.exl <= 1'b1;
                causeBd <= inDelaySlot;
                causeExcCode <= exc.code;
            end else if (commitEret) begin
                status.exl <= 1'b0;
            end else if (mtc0) begin
                if (regNum == CP0_STATUS) begin
                    status.bev <= wrStatus.bev;
                    status.im <= wrStatus.im;
                    status.exl <= wrStatus.exl;
                    status.ie <= wrStatus.ie;
                end
                // software interrupt bits only
                if (regNum == CP0_CAUSE) begin
                    causeIp[1:0] <= memBundle.storeData[9:8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commitExc) begin
            epc <= inDelaySlot ? memBundle.pc - 32'd4 : memBundle.pc;
            if (exc.badVAddrWr) begin
                badVAddr <= exc.badAddr;
            end
        end else if (mtc0) begin
            if (regNum == CP0_EPC) begin
                epc <= memBundle.storeData;
            end
        end
    end

    assign causeWord = {causeBd, 15'd0, causeIp, 1'b0, causeExcCode, 2'b00};

    always_comb begin
        case (regNum)
            CP0_BADVADDR: cp0RdData = badVAddr;
            CP0_STATUS:   cp0RdData = status;
            CP0_CAUSE:    cp0RdData = causeWord;
            CP0_EPC:      cp0RdData = epc;
            default:      cp0RdData = 32'd0;
        endcase
    end

    assign statusBev = status.bev;
    assign statusExl = status.exl;

    // bubbles (pc 0) and delay-slot instructions never take an interrupt
    assign intPending = ((causeIp & status.im) != 8'h00) && status.ie && !status.exl &&
                        !inDelaySlot && (memBundle.pc != 32'd0);

endmodule

`default_nettype wire

// File: verilog/exceptionUnit.sv
`timescale 1ns/1ps
`default_nettype none

module exceptionUnit import memStagePkg::*; (
    input  excFlags_t   excFlags,
    input  logic        loadMisaligned,
    input  logic        storeMisaligned,
    input  logic        intPending,
    input  logic        statusBev,
    input  logic        statusExl,
    input  logic [31:0] aluOut,
    output excInfo_t    exc,
    output logic        flush,
    output logic [31:0] vector
);

    logic intTaken;

    // no nested interrupt while a handler is running
    assign intTaken = intPending && !statusExl;

    always_comb begin
        exc = '0;
        exc.badAddr = aluOut;
        if (intTaken) begin
            exc.taken = 1'b1;
            exc.code = EXC_INT;
        end else if (loadMisaligned) begin
            exc.taken = 1'b1;
            exc.code = EXC_ADEL;
            exc.badVAddrWr = 1'b1;
        end else if (storeMisaligned) begin
            exc.taken = 1'b1;
            exc.code = EXC_ADES;
            exc.badVAddrWr = 1'b1;
        end else if (excFlags.reservedInstr) begin
            exc.taken = 1'b1;
            exc.code = EXC_RI;
        end else if (excFlags.syscall) begin
            exc.taken = 1'b1;
            exc.code = EXC_SYS;
        end else if (excFlags.brk) begin
            exc.taken = 1'b1;
            exc.code = EXC_BP;
        end else if (excFlags.overflow) begin
            exc.taken = 1'b1;
            exc.code = EXC_OV;
        end else if (excFlags.eret) begin
            exc.isEret = 1'b1;
        end
    end

    assign flush = exc.taken || exc.isEret;

    // boot vector until software clears BEV
    assign vector = statusBev ? VEC_BOOT : VEC_NORMAL;

endmodule

`default_nettype wire

// File: verilog/memAccessAlign.sv
`timescale 1ns/1ps
`default_nettype none

module memAccessAlign import memStagePkg::*; (
    input  logic [1:0]  addrLow,
    input  loadKind_t   loadKind,
    input  storeKind_t  storeKind,
    input  logic [31:0] storeData,
    output logic [3:0]  wstrb,
    output logic [31:0] wdata,
    output logic        loadMisaligned,
    output logic        storeMisaligned
);

    logic halfLoad;

    assign halfLoad = (loadKind == ldHalf) || (loadKind == ldHalfU);

    // store data is replicated so the cache can pick any lane
    always_comb begin
        wstrb = 4'b0000;
        wdata = storeData;
        case (storeKind)
            stByte: begin
                wstrb = 4'b0001 << addrLow;
                wdata = {4{storeData[7:0]}};
            end
            stHalf: begin
                wstrb = addrLow[1] ? 4'b1100 : 4'b0011;
                wdata = {2{storeData[15:0]}};
            end
            stWord: begin
                wstrb = 4'b1111;
            end
            default: begin
                wstrb = 4'b0000;
            end
        endcase
    end

    assign loadMisaligned = (halfLoad && addrLow[0]) ||
                            ((loadKind == ldWord) && (addrLow != 2'b00));
    assign storeMisaligned = ((storeKind == stHalf) && addrLow[0]) ||
                             ((storeKind == stWord) && (addrLow != 2'b00));

endmodule

`default_nettype wire

// File: verilog/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage import memStagePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          memWr,
    input  logic          memFlush,
    input  logic          disWr,
    input  logic [5:0]    hwInt,
    input  exeMemBundle_t exeIn,
    output dataReq_t      dataReq,
    output logic          flush,
    output logic [31:0]   vector,
    output logic [31:0]   epc,
    output logic [31:0]   memPc,
    output logic [4:0]    fwdDst,
    output logic [31:0]   fwdResult,
    output logic          fwdRegWr
);

    exeMemBundle_t memBundle;
    logic          inDelaySlot;
    logic [3:0]    wstrb;
    logic [31:0]   wdata;
    logic          loadMisaligned;
    logic          storeMisaligned;
    logic [31:0]   physAddr;
    logic          cached;
    excInfo_t      exc;
    logic [31:0]   excVector;
    logic [31:0]   cp0RdData;
    logic          statusBev;
    logic          statusExl;
    logic          intPending;
    logic          isLoad;
    logic          isStore;

    memStageReg uMemStageReg (
        .clk         (clk),
        .rst         (rst),
        .memWr       (memWr),
        .memFlush    (memFlush),
        .exeIn       (exeIn),
        .memBundle   (memBundle),
        .inDelaySlot (inDelaySlot)
    );

    memAccessAlign uMemAccessAlign (
        .addrLow         (memBundle.aluOut[1:0]),
        .loadKind        (memBundle.loadKind),
        .storeKind       (memBundle.storeKind),
        .storeData       (memBundle.storeData),
        .wstrb           (wstrb),
        .wdata           (wdata),
        .loadMisaligned  (loadMisaligned),
        .storeMisaligned (storeMisaligned)
    );

    addrMapper uAddrMapper (
        .virtAddr (memBundle.aluOut),
        .physAddr (physAddr),
        .cached   (cached)
    );

    exceptionUnit uExceptionUnit (
        .excFlags        (memBundle.excFlags),
        .loadMisaligned  (loadMisaligned),
        .storeMisaligned (storeMisaligned),
        .intPending      (intPending),
        .statusBev       (statusBev),
        .statusExl       (statusExl),
        .aluOut          (memBundle.aluOut),
        .exc             (exc),
        .flush           (flush),
        .vector          (excVector)
    );

    cp0Regs uCp0Regs (
        .clk         (clk),
        .rst         (rst),
        .hwInt       (hwInt),
        .disWr       (disWr),
        .memBundle   (memBundle),
        .inDelaySlot (inDelaySlot),
        .exc         (exc),
        .cp0RdData   (cp0RdData),
        .statusBev   (statusBev),
        .statusExl   (statusExl),
        .intPending  (intPending),
        .epc         (epc)
    );

    assign isLoad = (memBundle.loadKind != ldNone);
    assign isStore = (memBundle.storeKind != stNone);

    // request repeats every cycle the access sits in MEM
    always_comb begin
        dataReq.valid = (isLoad || isStore) && !exc.taken && !disWr;
        dataReq.write = isStore;
        dataReq.physAddr = physAddr;
        dataReq.wstrb = wstrb;
        dataReq.wdata = wdata;
        dataReq.cached = cached;
    end

    // eret returns to the saved pc
    assign vector = exc.isEret ? epc : excVector;

    assign memPc = memBundle.pc;
    assign fwdDst = memBundle.dst;
    assign fwdResult = memBundle.cp0Rd ? cp0RdData : memBundle.aluOut;
    assign fwdRegWr = memBundle.regWr && !disWr && !exc.taken;

endmodule

`default_nettype wire

// File: verilog/memStagePkg.sv
`default_nettype none

package memStagePkg;

    typedef enum logic [2:0] {
        ldNone,
        ldByte,
        ldByteU,
        ldHalf,
        ldHalfU,
        ldWord
    } loadKind_t;

    typedef enum logic [1:0] {
        stNone,
        stByte,
        stHalf,
        stWord
    } storeKind_t;

    typedef struct packed {
        logic syscall;
        logic brk;
        logic reservedInstr;
        logic overflow;
        logic eret;
    } excFlags_t;

    // mfc0/mtc0 carry the cp0 register number in aluOut[4:0]
    // mtc0 write data travels in storeData
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] aluOut;
        logic [31:0] storeData;
        logic [4:0]  dst;
        loadKind_t   loadKind;
        storeKind_t  storeKind;
        logic        regWr;
        logic        cp0Wr;
        logic        cp0Rd;
        logic        isBranch;
        excFlags_t   excFlags;
    } exeMemBundle_t;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] physAddr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic        cached;
    } dataReq_t;

    typedef struct packed {
        logic        taken;
        logic        isEret;
        logic [4:0]  code;
        logic [31:0] badAddr;
        logic        badVAddrWr;
    } excInfo_t;

    // Status layout with only BEV, IM, EXL and IE implemented
    typedef struct packed {
        logic [8:0] rsvdHi;
        logic       bev;
        logic [5:0] rsvdMid;
        logic [7:0] im;
        logic [5:0] rsvdLo;
        logic       exl;
        logic       ie;
    } status_t;

    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    localparam logic [31:0] VEC_BOOT     = 32'hBFC0_0380;
    localparam logic [31:0] VEC_NORMAL   = 32'h8000_0180;
    localparam logic [31:0] STATUS_RESET = 32'h0040_0000;

    // top three address bits of the unmapped segments
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

endpackage

`default_nettype wire

// File: verilog/memStageReg.sv
`timescale 1ns/1ps
`default_nettype none

module memStageReg import memStagePkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          memWr,
    input  logic          memFlush,
    input  exeMemBundle_t exeIn,
    output exeMemBundle_t memBundle,
    output logic          inDelaySlot
);

    // a flush loads a bubble and overrides a stall
    always_ff @(posedge clk) begin
        if (rst || memFlush) begin
            memBundle <= '0;
        end else if (memWr) begin
            memBundle <= exeIn;
        end
    end

    // delay slot = the instruction that was in MEM before this one branched
    always_ff @(posedge clk) begin
        if (rst || memFlush) begin
            inDelaySlot <= 1'b0;
        end else if (memWr) begin
            inDelaySlot <= memBundle.isBranch;
        end
    end

endmodule

`default_nettype wire
